/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_nes_debugger -f sim.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "TEST PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* sim.f */
verilog/dbg_pkg.sv
verilog/pool_memory.sv
verilog/mem_arbiter.sv
verilog/dbg_value_regs.sv
verilog/dbg_command_engine.sv
verilog/nes_debugger_top.sv
tb/tb_nes_debugger.sv

/* tb/tb_nes_debugger.sv */
/*
 * Testbench for the NES debugger top. Sends host commands, drives a busy
 * NES port and checks every response byte against a reference model
 */

`timescale 1ns/1ns

module tb_nes_debugger;

    typedef logic [7:0] byte_q_t [$];

    // command plus response bytes per test, used to size the watchdog
    localparam int TEST_BYTES = 30 + 42 + 154 + 79 + 39 + 40;
    localparam int TIMEOUT_NS = TEST_BYTES * 200 + 20000;

    logic clk;
    logic reset;
    logic cmd_active;
    logic rx_dv;
    logic [7:0] rx_byte;
    logic tx_dv;
    logic [7:0] tx_byte;
    dbg_pkg::mem_req_t [dbg_pkg::POOL_COUNT-1:0] nes_req;
    logic [dbg_pkg::POOL_COUNT-1:0][7:0] nes_rdata;
    logic nes_reset;

    // reference model state
    logic [7:0]  model_mem [dbg_pkg::POOL_COUNT][1024];
    logic        model_nes_reset;
    logic [1:0]  model_pool;
    logic [15:0] model_scratch;

    byte_q_t cmd_buf;
    byte_q_t exp_q;
    int      seed;
    int      errors;
    int      checks;

    nes_debugger_top nes_debugger_top_i (
        .i_clk        (clk),
        .i_reset      (reset),
        .i_cmd_active (cmd_active),
        .i_rx_dv      (rx_dv),
        .i_rx_byte    (rx_byte),
        .o_tx_dv      (tx_dv),
        .o_tx_byte    (tx_byte),
        .i_nes_req    (nes_req),
        .o_nes_rdata  (nes_rdata),
        .o_nes_reset  (nes_reset)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input logic [15:0] actual, input logic [15:0] expected,
                         input string msg);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    function automatic logic [7:0] rand_byte();
        rand_byte = 8'($random(seed));
    endfunction

    function automatic logic [15:0] model_value(input logic [15:0] id);
        case (id)
        dbg_pkg::VALUE_NES_RESET: model_value = {15'd0, model_nes_reset};
        dbg_pkg::VALUE_MEM_POOL:  model_value = {14'd0, model_pool};
        dbg_pkg::VALUE_SCRATCH:   model_value = model_scratch;
        default:                  model_value = 16'd0;
        endcase
    endfunction

    // expected response bytes go to exp_q, writes update the model
    function automatic void ref_response(input byte_q_t cmd);
        logic [15:0] addr;
        logic [15:0] word;
        logic [9:0]  a;
        int          count_i;
        if (cmd.size() < 3)
        begin
            return;
        end
        addr    = {cmd[1], cmd[2]};
        count_i = (cmd.size() >= 5) ? int'({cmd[3], cmd[4]}) : 0;
        case (cmd[0])
        dbg_pkg::CMD_READ_MEM:
        begin
            for (int i = 0; i < count_i; i++)
            begin
                a = addr[9:0] + i[9:0];
                exp_q.push_back(model_mem[model_pool][a]);
            end
        end
        dbg_pkg::CMD_WRITE_MEM:
        begin
            // a cut-off command writes only the bytes that arrived
            for (int i = 0; i < count_i && 5 + i < cmd.size(); i++)
            begin
                a = addr[9:0] + i[9:0];
                model_mem[model_pool][a] = cmd[5 + i];
            end
        end
        dbg_pkg::CMD_READ_VALUE:
        begin
            word = model_value(addr);
            exp_q.push_back(word[15:8]);
            exp_q.push_back(word[7:0]);
        end
        dbg_pkg::CMD_WRITE_VALUE:
        begin
            word = {cmd[3], cmd[4]};
            case (addr)
            dbg_pkg::VALUE_NES_RESET: model_nes_reset = word[0];
            dbg_pkg::VALUE_MEM_POOL:  model_pool      = word[1:0];
            dbg_pkg::VALUE_SCRATCH:   model_scratch   = word;
            default:                  model_scratch   = model_scratch;
            endcase
        end
        default:
        begin
            model_scratch = model_scratch;
        end
        endcase
    endfunction

    function automatic void build_mem_cmd(input logic [7:0] op, input logic [15:0] addr,
                                          input logic [15:0] count);
        cmd_buf.delete();
        cmd_buf.push_back(op);
        cmd_buf.push_back(addr[15:8]);
        cmd_buf.push_back(addr[7:0]);
        cmd_buf.push_back(count[15:8]);
        cmd_buf.push_back(count[7:0]);
    endfunction

    function automatic void build_value_read(input logic [15:0] id);
        cmd_buf.delete();
        cmd_buf.push_back(dbg_pkg::CMD_READ_VALUE);
        cmd_buf.push_back(id[15:8]);
        cmd_buf.push_back(id[7:0]);
    endfunction

    function automatic void build_value_write(input logic [15:0] id, input logic [15:0] data);
        build_mem_cmd(dbg_pkg::CMD_WRITE_VALUE, id, data);
    endfunction

    // one strobe every 6 cycles
    task automatic send_bytes(input byte_q_t bytes);
        foreach (bytes[i])
        begin
            @(posedge clk);
            #1;
            rx_dv   = 1'b1;
            rx_byte = bytes[i];
            @(posedge clk);
            #1;
            rx_dv = 1'b0;
            repeat (4) @(posedge clk);
        end
    endtask

    task automatic wait_responses();
        while (exp_q.size() != 0)
        begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
    endtask

    task automatic run_cmd();
        ref_response(cmd_buf);
        send_bytes(cmd_buf);
        wait_responses();
    endtask

    // NES side write then read back, with one free cycle in four
    task automatic nes_traffic(input logic [1:0] pool, input int cycles);
        dbg_pkg::mem_req_t req;
        logic [9:0] addr;
        logic [7:0] data;
        logic       do_read;
        logic       rd_sent;
        logic       rd_check;
        logic [7:0] rd_expect;
        logic [7:0] rd_expect_next;
        addr           = 10'h200;
        do_read        = 1'b0;
        rd_sent        = 1'b0;
        rd_expect_next = 8'h00;
        for (int c = 0; c <= cycles; c++)
        begin
            @(posedge clk);
            #1;
            // the read driven last cycle was taken at this edge
            rd_check  = rd_sent;
            rd_expect = rd_expect_next;
            rd_sent   = 1'b0;
            req       = '0;
            if (c < cycles && (c % 4) != 3)
            begin
                req.en   = 1'b1;
                req.addr = {6'd0, addr};
                if (do_read)
                begin
                    rd_sent        = 1'b1;
                    rd_expect_next = model_mem[pool][addr];
                    addr           = addr + 10'd1;
                end
                else
                begin
                    data                  = rand_byte();
                    req.we                = 1'b1;
                    req.wdata             = data;
                    model_mem[pool][addr] = data;
                end
                do_read = !do_read;
            end
            nes_req[pool] = req;
            @(negedge clk);
            if (rd_check)
            begin
                check(16'(nes_rdata[pool]), 16'(rd_expect), "NES read data");
            end
        end
    endtask

    // every response byte is compared as it arrives
    always @(negedge clk)
    begin
        if (tx_dv)
        begin
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("Unexpected response byte %h at %0t ns", tx_byte, $time);
            end
            else
            begin
                check(16'(tx_byte), 16'(exp_q.pop_front()), "response byte");
            end
        end
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        logic [15:0] word;
        seed            = 32'h122;
        errors          = 0;
        checks          = 0;
        reset           = 1'b1;
        cmd_active      = 1'b0;
        rx_dv           = 1'b0;
        rx_byte         = 8'h00;
        nes_req         = '0;
        model_nes_reset = 1'b1;
        model_pool      = 2'd0;
        model_scratch   = 16'd0;
        repeat (8) @(posedge clk);
        #1;
        reset      = 1'b0;
        cmd_active = 1'b1;
        @(negedge clk);

        // values after reset, unknown id reads 0 even after a write
        check(16'(nes_reset), 16'd1, "NES reset after reset");
        check(16'(tx_dv), 16'd0, "tx strobe after reset");
        build_value_read(dbg_pkg::VALUE_NES_RESET);
        run_cmd();
        build_value_read(dbg_pkg::VALUE_MEM_POOL);
        run_cmd();
        build_value_read(dbg_pkg::VALUE_SCRATCH);
        run_cmd();
        build_value_read(16'h0055);
        run_cmd();
        build_value_write(16'h0055, 16'h1234);
        run_cmd();
        build_value_read(16'h0055);
        run_cmd();

        // pool 0 write and read back
        build_mem_cmd(dbg_pkg::CMD_WRITE_MEM, 16'h0010, 16'd16);
        repeat (16) cmd_buf.push_back(rand_byte());
        run_cmd();
        build_mem_cmd(dbg_pkg::CMD_READ_MEM, 16'h0010, 16'd16);
        run_cmd();

        // pools are separate, top bits of each byte tag the pool
        for (int k = 0; k < 4; k++)
        begin
            build_value_write(dbg_pkg::VALUE_MEM_POOL, 16'(k));
            run_cmd();
            build_mem_cmd(dbg_pkg::CMD_WRITE_MEM, 16'h03fc, 16'd8);
            repeat (8) cmd_buf.push_back({2'(k), 6'($random(seed))});
            run_cmd();
        end
        for (int k = 0; k < 4; k++)
        begin
            build_value_write(dbg_pkg::VALUE_MEM_POOL, 16'(k));
            run_cmd();
            build_mem_cmd(dbg_pkg::CMD_READ_MEM, 16'h03fc, 16'd8);
            run_cmd();
        end
        build_value_write(dbg_pkg::VALUE_NES_RESET, 16'd0);
        run_cmd();
        @(negedge clk);
        check(16'(nes_reset), 16'd0, "NES reset released");
        build_value_read(dbg_pkg::VALUE_NES_RESET);
        run_cmd();

        // debugger read of pool 1 while its NES port is busy
        build_value_write(dbg_pkg::VALUE_MEM_POOL, 16'd1);
        run_cmd();
        build_mem_cmd(dbg_pkg::CMD_WRITE_MEM, 16'h0100, 16'd32);
        repeat (32) cmd_buf.push_back(rand_byte());
        run_cmd();
        build_mem_cmd(dbg_pkg::CMD_READ_MEM, 16'h0100, 16'd32);
        fork
            run_cmd();
            nes_traffic(2'd1, 200);
        join

        // chip select drops after 3 of 8 data bytes
        build_mem_cmd(dbg_pkg::CMD_WRITE_MEM, 16'h0080, 16'd8);
        repeat (8) cmd_buf.push_back(rand_byte());
        run_cmd();
        build_mem_cmd(dbg_pkg::CMD_WRITE_MEM, 16'h0080, 16'd8);
        repeat (3) cmd_buf.push_back(rand_byte());
        ref_response(cmd_buf);
        send_bytes(cmd_buf);
        @(posedge clk);
        #1;
        cmd_active = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        cmd_active = 1'b1;
        build_mem_cmd(dbg_pkg::CMD_READ_MEM, 16'h0080, 16'd8);
        run_cmd();
        build_value_read(dbg_pkg::VALUE_MEM_POOL);
        run_cmd();

        // scratch round trips
        for (int n = 0; n < 4; n++)
        begin
            word = 16'($random(seed));
            build_value_write(dbg_pkg::VALUE_SCRATCH, word);
            run_cmd();
            build_value_read(dbg_pkg::VALUE_SCRATCH);
            run_cmd();
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verilog/dbg_command_engine.sv */
/*
 * Debug command engine. Parses host command bytes, runs memory and
 * debug value accesses, and sends the response bytes back
 */

`timescale 1ns/1ns

module dbg_command_engine (
    input  logic                                           i_clk,
    input  logic                                           i_reset,
    input  logic                                           i_cmd_active,
    input  logic                                           i_rx_dv,
    input  logic [dbg_pkg::DATA_W-1:0]                     i_rx_byte,
    output logic                                           o_tx_dv,
    output logic [dbg_pkg::DATA_W-1:0]                     o_tx_byte,
    input  dbg_pkg::dbg_pool_e                             i_pool,
    output dbg_pkg::mem_req_t                              o_mem_req,
    output dbg_pkg::dbg_pool_e                             o_mem_pool,
    input  dbg_pkg::mem_rsp_t [dbg_pkg::POOL_COUNT-1:0]    i_mem_rsp,
    output dbg_pkg::value_req_t                            o_value_req,
    input  logic [15:0]                                    i_value_rdata
);

    dbg_pkg::engine_state_e state_q;
    dbg_pkg::dbg_cmd_e      cmd_q;
    dbg_pkg::dbg_pool_e     pool_q;
    dbg_pkg::mem_req_t      req_q;

    logic [2:0]  field_left_q;
    logic [23:0] fields_q;
    logic [15:0] count_q;

    logic [15:0] field_addr;
    logic [15:0] field_word;
    logic        field_last;
    logic        cmd_is_value;
    logic        mem_ack;
    logic [dbg_pkg::DATA_W-1:0] mem_rdata;

    // first field of a 4 byte header, and the last two bytes seen
    assign field_addr   = fields_q[23:8];
    assign field_word   = {fields_q[7:0], i_rx_byte};
    assign field_last   = (state_q == dbg_pkg::ST_FIELDS) && i_cmd_active && i_rx_dv &&
                          (field_left_q == 3'd1);
    assign cmd_is_value = (cmd_q == dbg_pkg::CMD_READ_VALUE) ||
                          (cmd_q == dbg_pkg::CMD_WRITE_VALUE);

    // only the pool latched at command start answers
    assign mem_ack   = i_mem_rsp[pool_q].ack;
    assign mem_rdata = i_mem_rsp[pool_q].rdata;

    assign o_mem_req  = req_q;
    assign o_mem_pool = pool_q;

    // value access fires on the cycle the last field byte arrives
    always_comb
    begin
        o_value_req.en    = field_last && cmd_is_value;
        o_value_req.we    = (cmd_q == dbg_pkg::CMD_WRITE_VALUE);
        o_value_req.id    = (cmd_q == dbg_pkg::CMD_READ_VALUE) ? field_word : field_addr;
        o_value_req.wdata = field_word;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state_q   <= dbg_pkg::ST_IDLE;
            cmd_q     <= dbg_pkg::CMD_READ_MEM;
            pool_q    <= dbg_pkg::POOL_PRG;
            req_q.en  <= 1'b0;
            o_tx_dv   <= 1'b0;
        end
        else
        begin
            o_tx_dv <= 1'b0;

            if (!i_cmd_active)
            begin
                // chip select gone, drop whatever was in flight
                state_q  <= dbg_pkg::ST_IDLE;
                req_q.en <= 1'b0;
            end
            else
            begin
                case (state_q)
                dbg_pkg::ST_IDLE:
                begin
                    if (i_rx_dv)
                    begin
                        case (i_rx_byte)
                        dbg_pkg::CMD_READ_MEM, dbg_pkg::CMD_WRITE_MEM,
                        dbg_pkg::CMD_WRITE_VALUE:
                        begin
                            cmd_q        <= dbg_pkg::dbg_cmd_e'(i_rx_byte);
                            pool_q       <= i_pool;
                            field_left_q <= 3'd4;
                            state_q      <= dbg_pkg::ST_FIELDS;
                        end
                        dbg_pkg::CMD_READ_VALUE:
                        begin
                            cmd_q        <= dbg_pkg::CMD_READ_VALUE;
                            pool_q       <= i_pool;
                            field_left_q <= 3'd2;
                            state_q      <= dbg_pkg::ST_FIELDS;
                        end
                        default:
                        begin
                            // unknown opcode, stay idle
                            state_q <= dbg_pkg::ST_IDLE;
                        end
                        endcase
                    end
                end

                dbg_pkg::ST_FIELDS:
                begin
                    if (i_rx_dv)
                    begin
                        fields_q     <= {fields_q[15:0], i_rx_byte};
                        field_left_q <= field_left_q - 3'd1;

                        if (field_left_q == 3'd1)
                        begin
                            case (cmd_q)
                            dbg_pkg::CMD_READ_MEM:
                            begin
                                req_q.addr <= field_addr;
                                req_q.we   <= 1'b0;
                                count_q    <= field_word;
                                if (field_word == 16'd0)
                                begin
                                    state_q <= dbg_pkg::ST_IDLE;
                                end
                                else
                                begin
                                    req_q.en <= 1'b1;
                                    state_q  <= dbg_pkg::ST_MEM_RD;
                                end
                            end
                            dbg_pkg::CMD_WRITE_MEM:
                            begin
                                req_q.addr <= field_addr;
                                count_q    <= field_word;
                                state_q    <= (field_word == 16'd0) ? dbg_pkg::ST_IDLE :
                                                                      dbg_pkg::ST_WR_DATA;
                            end
                            dbg_pkg::CMD_READ_VALUE:
                            begin
                                state_q <= dbg_pkg::ST_VAL_HI;
                            end
                            default:
                            begin
                                // value write already went out on o_value_req
                                state_q <= dbg_pkg::ST_IDLE;
                            end
                            endcase
                        end
                    end
                end

                dbg_pkg::ST_MEM_RD:
                begin
                    if (mem_ack)
                    begin
                        o_tx_dv    <= 1'b1;
                        o_tx_byte  <= mem_rdata;
                        req_q.en   <= 1'b0;
                        req_q.addr <= req_q.addr + 16'd1;
                        count_q    <= count_q - 16'd1;
                        if (count_q == 16'd1)
                        begin
                            state_q <= dbg_pkg::ST_IDLE;
                        end
                    end
                    else if (!req_q.en)
                    begin
                        // one idle cycle after each ack, then next byte
                        req_q.en <= 1'b1;
                    end
                end

                dbg_pkg::ST_WR_DATA:
                begin
                    if (i_rx_dv)
                    begin
                        req_q.en    <= 1'b1;
                        req_q.we    <= 1'b1;
                        req_q.wdata <= i_rx_byte;
                        state_q     <= dbg_pkg::ST_WR_ACK;
                    end
                end

                dbg_pkg::ST_WR_ACK:
                begin
                    if (mem_ack)
                    begin
                        req_q.en   <= 1'b0;
                        req_q.addr <= req_q.addr + 16'd1;
                        count_q    <= count_q - 16'd1;
                        state_q    <= (count_q == 16'd1) ? dbg_pkg::ST_IDLE :
                                                           dbg_pkg::ST_WR_DATA;
                    end
                end

                dbg_pkg::ST_VAL_HI:
                begin
                    o_tx_dv   <= 1'b1;
                    o_tx_byte <= i_value_rdata[15:8];
                    state_q   <= dbg_pkg::ST_VAL_LO;
                end

                dbg_pkg::ST_VAL_LO:
                begin
                    // rdata holds until the next value access
                    o_tx_dv   <= 1'b1;
                    o_tx_byte <= i_value_rdata[7:0];
                    state_q   <= dbg_pkg::ST_IDLE;
                end

                default:
                begin
                    state_q <= dbg_pkg::ST_IDLE;
                end
                endcase
            end
        end
    end

endmodule

/* verilog/dbg_pkg.sv */
/*
 * Shared types for the NES debug controller: sizes, command opcodes,
 * value ids, memory pool ids and the request/response bundles
 */

package dbg_pkg;

    // sizes
    localparam int POOL_COUNT  = 4;
    localparam int POOL_ADDR_W = 10;    // 1 KiB per pool
    localparam int DATA_W      = 8;

    // memory pool select
    typedef enum logic [1:0] {
        POOL_PRG          = 2'd0,
        POOL_RAM          = 2'd1,
        POOL_PATTERNTABLE = 2'd2,
        POOL_NAMETABLE    = 2'd3
    } dbg_pool_e;

    // first byte of every host command
    typedef enum logic [7:0] {
        CMD_READ_MEM    = 8'h01,
        CMD_WRITE_MEM   = 8'h02,
        CMD_READ_VALUE  = 8'h03,
        CMD_WRITE_VALUE = 8'h04
    } dbg_cmd_e;

    // debug value ids
    typedef enum logic [15:0] {
        VALUE_NES_RESET = 16'd0,
        VALUE_MEM_POOL  = 16'd1,
        VALUE_SCRATCH   = 16'd2
    } dbg_value_e;

    // command engine FSM
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FIELDS,
        ST_MEM_RD,
        ST_WR_DATA,
        ST_WR_ACK,
        ST_VAL_HI,
        ST_VAL_LO
    } engine_state_e;

    typedef struct packed {
        logic              en;
        logic              we;
        logic [15:0]       addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic        en;
        logic        we;
        logic [15:0] id;
        logic [15:0] wdata;
    } value_req_t;

endpackage

/* verilog/dbg_value_regs.sv */
/*
 * Debug value registers: NES reset hold, debugger pool select and a
 * scratch word, addressed by 16-bit value id
 */

`timescale 1ns/1ns

module dbg_value_regs (
    input  logic                i_clk,
    input  logic                i_reset,
    input  dbg_pkg::value_req_t i_value_req,
    output logic [15:0]         o_value_rdata,
    output logic                o_nes_reset,
    output dbg_pkg::dbg_pool_e  o_pool
);

    logic [15:0] scratch_q;

    // writes
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_nes_reset <= 1'b1;    // NES held in reset until released
            o_pool      <= dbg_pkg::POOL_PRG;
            scratch_q   <= 16'd0;
        end
        else if (i_value_req.en && i_value_req.we)
        begin
            case (i_value_req.id)
            dbg_pkg::VALUE_NES_RESET: o_nes_reset <= i_value_req.wdata[0];
            dbg_pkg::VALUE_MEM_POOL:  o_pool      <= dbg_pkg::dbg_pool_e'(i_value_req.wdata[1:0]);
            dbg_pkg::VALUE_SCRATCH:   scratch_q   <= i_value_req.wdata;
            default:
            begin
                // unknown id, write dropped
                scratch_q <= scratch_q;
            end
            endcase
        end
    end

    // registered read, valid the cycle after en
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_value_rdata <= 16'd0;
        end
        else if (i_value_req.en)
        begin
            case (i_value_req.id)
            dbg_pkg::VALUE_NES_RESET: o_value_rdata <= {15'd0, o_nes_reset};
            dbg_pkg::VALUE_MEM_POOL:  o_value_rdata <= {14'd0, o_pool};
            dbg_pkg::VALUE_SCRATCH:   o_value_rdata <= scratch_q;
            default:                  o_value_rdata <= 16'd0;
            endcase
        end
    end

endmodule

/* verilog/mem_arbiter.sv */
/*
 * Pool arbiter. Shares one memory pool between the NES port and the
 * debugger; the NES always wins and the debugger waits for a free cycle
 */

`timescale 1ns/1ns

module mem_arbiter #(
    parameter dbg_pkg::dbg_pool_e POOL_ID = dbg_pkg::POOL_PRG
) (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  dbg_pkg::mem_req_t             i_nes_req,
    output logic [dbg_pkg::DATA_W-1:0]    o_nes_rdata,
    input  dbg_pkg::mem_req_t             i_dbg_req,
    input  dbg_pkg::dbg_pool_e            i_dbg_pool,
    output dbg_pkg::mem_rsp_t             o_dbg_rsp,
    output dbg_pkg::mem_req_t             o_mem_req,
    input  logic [dbg_pkg::DATA_W-1:0]    i_mem_rdata
);

    logic dbg_sel;
    logic dbg_grant;
    logic dbg_served_q;
    logic dbg_owned_q;
    logic nes_owned_q;
    logic [dbg_pkg::DATA_W-1:0] nes_hold_q;

    assign dbg_sel   = i_dbg_req.en && (i_dbg_pool == POOL_ID);
    // a held request is served once, until the debugger drops en
    assign dbg_grant = dbg_sel && !i_nes_req.en && !dbg_served_q;

    always_comb
    begin
        if (i_nes_req.en)
        begin
            o_mem_req = i_nes_req;
        end
        else if (dbg_grant)
        begin
            o_mem_req = i_dbg_req;
        end
        else
        begin
            o_mem_req = '0;
        end
    end

    // track the owner of the access whose data returns this cycle
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            dbg_served_q <= 1'b0;
            dbg_owned_q  <= 1'b0;
            nes_owned_q  <= 1'b0;
        end
        else
        begin
            dbg_owned_q <= dbg_grant;
            nes_owned_q <= i_nes_req.en;
            if (dbg_grant)
            begin
                dbg_served_q <= 1'b1;
            end
            else if (!dbg_sel)
            begin
                dbg_served_q <= 1'b0;
            end
        end
    end

    // NES keeps its last read data while the debugger uses the pool
    always_ff @(posedge i_clk)
    begin
        if (nes_owned_q)
        begin
            nes_hold_q <= i_mem_rdata;
        end
    end

    assign o_nes_rdata     = nes_owned_q ? i_mem_rdata : nes_hold_q;
    assign o_dbg_rsp.ack   = dbg_owned_q;
    assign o_dbg_rsp.rdata = dbg_owned_q ? i_mem_rdata : '0;

endmodule

/* verilog/nes_debugger_top.sv */
/*
 * NES debugger top. Command engine, debug value registers and one
 * arbiter/memory pair per pool, shared with the NES memory ports
 */

`timescale 1ns/1ns

module nes_debugger_top (
    input  logic                                                i_clk,
    input  logic                                                i_reset,
    input  logic                                                i_cmd_active,
    input  logic                                                i_rx_dv,
    input  logic [dbg_pkg::DATA_W-1:0]                          i_rx_byte,
    output logic                                                o_tx_dv,
    output logic [dbg_pkg::DATA_W-1:0]                          o_tx_byte,
    input  dbg_pkg::mem_req_t [dbg_pkg::POOL_COUNT-1:0]         i_nes_req,
    output logic [dbg_pkg::POOL_COUNT-1:0][dbg_pkg::DATA_W-1:0] o_nes_rdata,
    output logic                                                o_nes_reset
);

    dbg_pkg::mem_req_t                           dbg_mem_req;
    dbg_pkg::dbg_pool_e                          dbg_mem_pool;
    dbg_pkg::mem_rsp_t [dbg_pkg::POOL_COUNT-1:0] dbg_mem_rsp;

    dbg_pkg::value_req_t value_req;
    logic [15:0]         value_rdata;
    dbg_pkg::dbg_pool_e  value_pool;

    dbg_command_engine dbg_command_engine_i (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_cmd_active  (i_cmd_active),
        .i_rx_dv       (i_rx_dv),
        .i_rx_byte     (i_rx_byte),
        .o_tx_dv       (o_tx_dv),
        .o_tx_byte     (o_tx_byte),
        .i_pool        (value_pool),
        .o_mem_req     (dbg_mem_req),
        .o_mem_pool    (dbg_mem_pool),
        .i_mem_rsp     (dbg_mem_rsp),
        .o_value_req   (value_req),
        .i_value_rdata (value_rdata)
    );

    // reset hold and pool select live here
    dbg_value_regs dbg_value_regs_i (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_value_req   (value_req),
        .o_value_rdata (value_rdata),
        .o_nes_reset   (o_nes_reset),
        .o_pool        (value_pool)
    );

    // one arbiter and memory per pool, the debugger request is broadcast
    for (genvar k = 0; k < dbg_pkg::POOL_COUNT; k++)
    begin : g_pool
        dbg_pkg::mem_req_t          mem_req;
        logic [dbg_pkg::DATA_W-1:0] mem_rdata;

        mem_arbiter #(
            .POOL_ID (dbg_pkg::dbg_pool_e'(k))
        ) mem_arbiter_i (
            .i_clk       (i_clk),
            .i_reset     (i_reset),
            .i_nes_req   (i_nes_req[k]),
            .o_nes_rdata (o_nes_rdata[k]),
            .i_dbg_req   (dbg_mem_req),
            .i_dbg_pool  (dbg_mem_pool),
            .o_dbg_rsp   (dbg_mem_rsp[k]),
            .o_mem_req   (mem_req),
            .i_mem_rdata (mem_rdata)
        );

        pool_memory pool_memory_i (
            .i_clk     (i_clk),
            .i_mem_req (mem_req),
            .o_rdata   (mem_rdata)
        );
    end

endmodule

/* verilog/pool_memory.sv */
/*
 * 1 KiB single-port byte memory for one pool, with registered read data
 */

`timescale 1ns/1ns

module pool_memory (
    input  logic                        i_clk,
    input  dbg_pkg::mem_req_t           i_mem_req,
    output logic [dbg_pkg::DATA_W-1:0]  o_rdata
);

    logic [dbg_pkg::DATA_W-1:0] mem [2**dbg_pkg::POOL_ADDR_W];

    logic [dbg_pkg::POOL_ADDR_W-1:0] addr;

    // upper address bits ignored, pool wraps at 1 KiB
    assign addr = i_mem_req.addr[dbg_pkg::POOL_ADDR_W-1:0];

    always_ff @(posedge i_clk)
    begin
        if (i_mem_req.en)
        begin
            if (i_mem_req.we)
            begin
                mem[addr] <= i_mem_req.wdata;
            end
            o_rdata <= mem[addr];   // read before write
        end
    end

endmodule
